// ==== tb.f ====
design/gpu_pkg.sv
design/sync_fifo.sv
design/cmd_processor.sv
design/clear_engine.sv
design/mem_arbiter.sv
design/gpu_top.sv
bench/tb_gpu_top.sv

// ==== Bender.yml ====
package:
  name: gpu_cmd_mem

dependencies: {}

sources:
  # Package first, then leaf modules, then the top level
  - design/gpu_pkg.sv
  - design/sync_fifo.sv
  - design/cmd_processor.sv
  - design/clear_engine.sv
  - design/mem_arbiter.sv
  - design/gpu_top.sv

  # Testbench
  - target: test
    files:
      - bench/tb_gpu_top.sv

// ==== bench/tb_gpu_top.sv ====
`timescale 1ns/1ps

module tb_gpu_top;

    localparam int CMD_DEPTH     = 32;
    localparam int RSP_DEPTH     = 4;
    localparam int ALMOST_MARGIN = 4;

    // Test sizes, also used for the watchdog limit
    localparam int HOST_N    = 16;
    localparam int CLR_A     = 24;
    localparam int CLR_B     = 10;
    localparam int OVL_CLR   = 40;
    localparam int OVL_HOST  = 12;
    localparam int BP_HOST   = 40;
    localparam int BP_READS  = 10;
    localparam int CMD_TOTAL = 9 + (1 + HOST_N) + 7 + (4 + OVL_HOST) + (1 + BP_HOST) + BP_READS;
    localparam int CLR_WORDS = CLR_A + CLR_B + OVL_CLR;
    localparam int TIMEOUT_NS = CMD_TOTAL * 200 + CLR_WORDS * 200 + 20000;

    logic              clk_core;
    logic              rst;
    logic              cmd_valid;
    gpu_pkg::cmd_t     cmd;
    logic              cmd_ready;
    logic              rsp_valid;
    logic [63:0]       rsp_data;
    logic              rsp_ready;
    logic              mem_valid;
    gpu_pkg::mem_req_t mem_req;
    logic              mem_ready;
    logic              cmd_full;
    logic              cmd_empty;

    // Pending stimulus and expected results
    gpu_pkg::cmd_t cmd_q[$];
    logic [63:0]   exp_rsp[$];
    logic [31:0]   exp_mem[logic [23:0]];
    bit            exp_is_fill[logic [23:0]];
    logic [31:0]   mem_model[logic [23:0]];

    // Reference register state
    logic [23:0] ref_fb;
    logic [31:0] ref_color;
    logic [23:0] ref_ptr;

    int   sent_n, taken_n, host_n, fill_n, exp_host_n, exp_fill_n;
    logic cmd_taken;
    logic mem_hold;
    logic rsp_hold;

    gpu_top #(
        .CMD_DEPTH(CMD_DEPTH),
        .RSP_DEPTH(RSP_DEPTH),
        .ALMOST_MARGIN(ALMOST_MARGIN)
    ) u_dut (
        .clk_core(clk_core), .rst(rst),
        .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_ready(rsp_ready),
        .mem_valid(mem_valid), .mem_req(mem_req), .mem_ready(mem_ready),
        .cmd_full(cmd_full), .cmd_empty(cmd_empty)
    );

    // ============================================================
    // Checking and reference model
    // ============================================================

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // Applies one command to the register rules, returns read data
    function automatic logic [63:0] ref_model(input gpu_pkg::cmd_t c);
        logic [63:0] rd;
        logic [23:0] a;
        int          i;
        rd = '0;
        if (c.rw) begin
            case (c.addr)
                gpu_pkg::REG_FB_DRAW:     rd = {40'd0, ref_fb};
                gpu_pkg::REG_CLEAR_COLOR: rd = {32'd0, ref_color};
                gpu_pkg::REG_MEM_ADDR:    rd = {40'd0, ref_ptr};
                gpu_pkg::REG_ID:          rd = gpu_pkg::GPU_ID;
                default:                  rd = '0;
            endcase
        end else begin
            case (c.addr)
                gpu_pkg::REG_FB_DRAW:     ref_fb = c.data[23:0];
                gpu_pkg::REG_CLEAR_COLOR: ref_color = c.data[31:0];
                gpu_pkg::REG_MEM_ADDR:    ref_ptr = c.data[23:0];
                // Fill of count words from the draw base
                gpu_pkg::REG_CLEAR: begin
                    for (i = 0; i < int'(c.data[15:0]); i++) begin
                        a = ref_fb + 24'(i);
                        exp_mem[a] = ref_color;
                        exp_is_fill[a] = 1'b1;
                        exp_fill_n++;
                    end
                end
                gpu_pkg::REG_MEM_DATA: begin
                    exp_mem[ref_ptr] = c.data[31:0];
                    exp_is_fill[ref_ptr] = 1'b0;
                    exp_host_n++;
                    ref_ptr = ref_ptr + 24'd1;
                end
                default: ;
            endcase
        end
        return rd;
    endfunction

    task automatic send(input logic rw, input gpu_pkg::reg_addr_t addr, input logic [63:0] data);
        gpu_pkg::cmd_t c;
        c.rw   = rw;
        c.addr = addr;
        c.data = data;
        if (rw) begin
            exp_rsp.push_back(ref_model(c));
        end else begin
            void'(ref_model(c));
        end
        cmd_q.push_back(c);
        sent_n++;
    endtask

    // Host write data with junk in the upper half
    function automatic logic [63:0] word_pattern(input int idx);
        return {32'hFFFF_0000 | 32'(idx), (32'(idx) * 32'h9E37_79B9) ^ 32'hC3A5_0F1E};
    endfunction

    // Waits for every queued command, response and write to complete
    task automatic drain();
        while (cmd_q.size() != 0 || cmd_valid || !cmd_empty || exp_rsp.size() != 0
               || (host_n + fill_n) != (exp_host_n + exp_fill_n)) begin
            @(negedge clk_core);
        end
    endtask

    task automatic check_mem();
        check_val(mem_model.size(), exp_mem.size(), "memory word count");
        foreach (exp_mem[a]) begin
            check_val(mem_model.exists(a), 1, $sformatf("word %h written", a));
            check_val(mem_model[a], exp_mem[a], $sformatf("word %h data", a));
        end
    endtask

    // ============================================================
    // Clock, drivers and monitors
    // ============================================================

    initial begin
        clk_core = 1'b0;
        forever #10 clk_core = ~clk_core;
    end

    // Random readies, held low on request
    initial begin
        void'($urandom(52896));
        mem_ready = 1'b0;
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk_core);
            mem_ready <= mem_hold ? 1'b0 : ($urandom_range(3) != 0);
            rsp_ready <= rsp_hold ? 1'b0 : ($urandom_range(3) != 0);
        end
    end

    // Command driver, next word after each accepted one
    always @(negedge clk_core) begin
        if (rst) begin
            cmd_valid <= 1'b0;
        end else if (!cmd_valid || cmd_taken) begin
            if (cmd_q.size() != 0) begin
                cmd       <= cmd_q.pop_front();
                cmd_valid <= 1'b1;
            end else begin
                cmd_valid <= 1'b0;
            end
        end
    end

    // Command acceptance and memory model
    always @(posedge clk_core) begin
        if (rst) begin
            cmd_taken <= 1'b0;
        end else begin
            cmd_taken <= cmd_valid && cmd_ready;
            if (cmd_valid && cmd_ready) taken_n++;
            if (mem_valid && mem_ready) begin
                check_val(exp_mem.exists(mem_req.addr), 1,
                          $sformatf("write to %h expected", mem_req.addr));
                check_val(mem_req.data, exp_mem[mem_req.addr], "memory write data");
                mem_model[mem_req.addr] = mem_req.data;
                if (exp_is_fill[mem_req.addr]) fill_n++;
                else host_n++;
            end
        end
    end

    // Response compare, strictly in order
    always @(posedge clk_core) begin
        if (!rst && rsp_valid && rsp_ready) begin
            check_val(exp_rsp.size() != 0, 1, "response outstanding");
            check_val(rsp_data, exp_rsp.pop_front(), "read response");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        mem_hold = 1'b0;
        rsp_hold = 1'b0;
        ref_fb = '0;
        ref_color = '0;
        ref_ptr = '0;
        repeat (10) @(posedge clk_core);
        @(negedge clk_core);
        rst = 1'b0;
        check_val({cmd_empty, cmd_full, rsp_valid, mem_valid}, 4'b1000, "reset state");

        // Register readback, unmapped and strobe reads give zero
        send(1'b1, gpu_pkg::REG_ID, '0);
        send(1'b0, gpu_pkg::REG_FB_DRAW, 64'hFFFF_FFFF_FF12_3456);
        send(1'b1, gpu_pkg::REG_FB_DRAW, '0);
        send(1'b0, gpu_pkg::REG_CLEAR_COLOR, 64'hDEAD_BEEF_CAFE_F00D);
        send(1'b1, gpu_pkg::REG_CLEAR_COLOR, '0);
        send(1'b0, gpu_pkg::REG_MEM_ADDR, 64'hAAAA_0000_00AB_CDEF);
        send(1'b1, gpu_pkg::REG_MEM_ADDR, '0);
        send(1'b1, 7'h05, '0);
        send(1'b1, gpu_pkg::REG_CLEAR, '0);
        drain();

        // Host writes at consecutive words
        send(1'b0, gpu_pkg::REG_MEM_ADDR, 64'h1000);
        for (int i = 0; i < HOST_N; i++) send(1'b0, gpu_pkg::REG_MEM_DATA, word_pattern(i));
        drain();
        check_mem();

        // Two back-to-back clears, then an empty one
        send(1'b0, gpu_pkg::REG_FB_DRAW, 64'h2000);
        send(1'b0, gpu_pkg::REG_CLEAR_COLOR, 64'h1122_3344);
        send(1'b0, gpu_pkg::REG_CLEAR, 64'(CLR_A));
        send(1'b0, gpu_pkg::REG_FB_DRAW, 64'h2000 + 64'(CLR_A));
        send(1'b0, gpu_pkg::REG_CLEAR_COLOR, 64'h5566_7788);
        send(1'b0, gpu_pkg::REG_CLEAR, 64'(CLR_B));
        send(1'b0, gpu_pkg::REG_CLEAR, 64'hFFFF_0000);
        drain();
        check_mem();
        check_val(mem_model.exists(24'h2000 + 24'(CLR_A + CLR_B)), 0, "word past the fill");

        // Host writes during a clear, disjoint range
        send(1'b0, gpu_pkg::REG_FB_DRAW, 64'h4000);
        send(1'b0, gpu_pkg::REG_CLEAR_COLOR, 64'h0BAD_F00D);
        send(1'b0, gpu_pkg::REG_CLEAR, 64'(OVL_CLR));
        send(1'b0, gpu_pkg::REG_MEM_ADDR, 64'h5000);
        for (int i = 0; i < OVL_HOST; i++) send(1'b0, gpu_pkg::REG_MEM_DATA, word_pattern(100 + i));
        drain();
        check_mem();
        check_val(host_n, exp_host_n, "host transfer total");
        check_val(fill_n, exp_fill_n, "fill transfer total");

        // Memory stalled until the command FIFO pushes back
        mem_hold = 1'b1;
        send(1'b0, gpu_pkg::REG_MEM_ADDR, 64'h6000);
        for (int i = 0; i < BP_HOST; i++) send(1'b0, gpu_pkg::REG_MEM_DATA, word_pattern(200 + i));
        while (!cmd_full) @(negedge clk_core);
        while (!(cmd_valid && !cmd_ready)) @(negedge clk_core);
        mem_hold = 1'b0;
        drain();
        check_val(cmd_empty, 1'b1, "command FIFO empty after drain");
        check_val(taken_n, sent_n, "commands accepted");
        check_mem();

        // Reads queued behind a stalled response channel
        rsp_hold = 1'b1;
        for (int i = 0; i < BP_READS; i++) begin
            case (i % 5)
                0:       send(1'b1, gpu_pkg::REG_ID, '0);
                1:       send(1'b1, gpu_pkg::REG_FB_DRAW, '0);
                2:       send(1'b1, gpu_pkg::REG_CLEAR_COLOR, '0);
                3:       send(1'b1, gpu_pkg::REG_MEM_ADDR, '0);
                default: send(1'b1, 7'h10, '0);
            endcase
        end
        while (cmd_q.size() != 0 || cmd_valid) @(negedge clk_core);
        repeat (20) @(negedge clk_core);
        check_val(rsp_valid, 1'b1, "responses waiting");
        rsp_hold = 1'b0;
        drain();
        check_val(taken_n, sent_n, "commands accepted");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== design/gpu_top.sv ====
`timescale 1ns/1ps

module gpu_top #(
    parameter int CMD_DEPTH     = 32,
    parameter int RSP_DEPTH     = 4,
    parameter int ALMOST_MARGIN = 4
) (
    input  logic              clk_core,
    input  logic              rst,

    // ============================================================
    // Host command and response channels
    // ============================================================
    input  logic              cmd_valid,
    input  gpu_pkg::cmd_t     cmd,
    output logic              cmd_ready,

    output logic              rsp_valid,
    output logic [63:0]       rsp_data,
    input  logic              rsp_ready,

    // ============================================================
    // Memory write channel
    // ============================================================
    output logic              mem_valid,
    output gpu_pkg::mem_req_t mem_req,
    input  logic              mem_ready,

    // GPIO-style status pins
    output logic              cmd_full,
    output logic              cmd_empty
);

    // FIFO head to processor
    logic              head_valid;
    gpu_pkg::cmd_t     head_cmd;
    logic              head_ready;

    // Processor to response FIFO
    logic              proc_rsp_valid;
    logic [63:0]       proc_rsp_data;
    logic              proc_rsp_ready;

    // Clear launch and status
    logic              clear_start;
    gpu_pkg::mem_req_t clear_base;
    logic [31:0]       clear_color;
    logic [15:0]       clear_count;
    logic              clear_busy;

    // Arbiter ports
    logic              host_valid;
    gpu_pkg::mem_req_t host_req;
    logic              host_ready;
    logic              fill_valid;
    gpu_pkg::mem_req_t fill_req;
    logic              fill_ready;

    sync_fifo #(
        .DEPTH(CMD_DEPTH),
        .ALMOST_MARGIN(ALMOST_MARGIN),
        .T(gpu_pkg::cmd_t)
    ) u_cmd_fifo (
        .clk_core(clk_core),
        .rst(rst),
        .in_valid(cmd_valid),
        .in_data(cmd),
        .in_ready(cmd_ready),
        .out_valid(head_valid),
        .out_data(head_cmd),
        .out_ready(head_ready),
        .almost_full(cmd_full),
        .empty(cmd_empty)
    );

    // Response FIFO status flags have no pins
    sync_fifo #(
        .DEPTH(RSP_DEPTH),
        .ALMOST_MARGIN(1),
        .T(logic [63:0])
    ) u_rsp_fifo (
        .clk_core(clk_core),
        .rst(rst),
        .in_valid(proc_rsp_valid),
        .in_data(proc_rsp_data),
        .in_ready(proc_rsp_ready),
        .out_valid(rsp_valid),
        .out_data(rsp_data),
        .out_ready(rsp_ready),
        .almost_full(),
        .empty()
    );

    cmd_processor u_cmd_proc (
        .clk_core(clk_core),
        .rst(rst),
        .cmd_valid(head_valid),
        .cmd(head_cmd),
        .cmd_ready(head_ready),
        .rsp_valid(proc_rsp_valid),
        .rsp_data(proc_rsp_data),
        .rsp_ready(proc_rsp_ready),
        .clear_start(clear_start),
        .clear_base(clear_base),
        .clear_color(clear_color),
        .clear_count(clear_count),
        .clear_busy(clear_busy),
        .host_valid(host_valid),
        .host_req(host_req),
        .host_ready(host_ready)
    );

    clear_engine u_clear (
        .clk_core(clk_core),
        .rst(rst),
        .start(clear_start),
        .base(clear_base),
        .color(clear_color),
        .count(clear_count),
        .busy(clear_busy),
        .fill_valid(fill_valid),
        .fill_req(fill_req),
        .fill_ready(fill_ready)
    );

    mem_arbiter u_arb (
        .clk_core(clk_core),
        .rst(rst),
        .host_valid(host_valid),
        .host_req(host_req),
        .host_ready(host_ready),
        .fill_valid(fill_valid),
        .fill_req(fill_req),
        .fill_ready(fill_ready),
        .mem_valid(mem_valid),
        .mem_req(mem_req),
        .mem_ready(mem_ready)
    );

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk_core,
    input  logic              rst,

    // Port 0, host writes, high priority
    input  logic              host_valid,
    input  gpu_pkg::mem_req_t host_req,
    output logic              host_ready,

    // Port 1, clear fill writes
    input  logic              fill_valid,
    input  gpu_pkg::mem_req_t fill_req,
    output logic              fill_ready,

    // External memory write channel
    output logic              mem_valid,
    output gpu_pkg::mem_req_t mem_req,
    input  logic              mem_ready
);

    logic grant_host;
    logic grant_fill;
    // Fill offer already on the bus and stalled
    logic fill_lock;

    // Host first, unless a stalled fill word is already on the bus
    assign grant_host = host_valid && !fill_lock;
    assign grant_fill = fill_valid && !grant_host;

    assign mem_valid  = grant_host || grant_fill;
    assign mem_req    = grant_host ? host_req : fill_req;

    // Only the winner sees ready
    assign host_ready = grant_host && mem_ready;
    assign fill_ready = grant_fill && mem_ready;

    // Keeps the external payload stable under back-pressure
    always_ff @(posedge clk_core) begin
        if (rst) begin
            fill_lock <= 1'b0;
        end else begin
            fill_lock <= grant_fill && !mem_ready;
        end
    end

    a_one_ready: assert property (@(posedge clk_core) disable iff (rst)
        !(host_ready && fill_ready));

    // Request held steady until the memory takes it
    a_req_stable: assert property (@(posedge clk_core) disable iff (rst)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_req)));

endmodule

// ==== design/clear_engine.sv ====
`timescale 1ns/1ps

module clear_engine (
    input  logic              clk_core,
    input  logic              rst,

    // Launch from the command processor
    input  logic              start,
    input  gpu_pkg::mem_req_t base,
    input  logic [31:0]       color,
    input  logic [15:0]       count,
    output logic              busy,

    // Fill write port to the arbiter
    output logic              fill_valid,
    output gpu_pkg::mem_req_t fill_req,
    input  logic              fill_ready
);

    logic [gpu_pkg::MEM_ADDR_W-1:0] addr_q;
    logic [gpu_pkg::MEM_DATA_W-1:0] color_q;
    logic [15:0]                    remain_q;
    logic                           launch;
    logic                           step;

    // Idle engine takes a non-empty run
    assign launch = start && !busy && (count != 16'd0);
    assign step   = fill_valid && fill_ready;

    // One word offered per cycle while words remain
    assign fill_valid    = busy && (remain_q != 16'd0);
    assign fill_req.addr = addr_q;
    assign fill_req.data = color_q;

    // Busy and remaining count
    always_ff @(posedge clk_core) begin
        if (rst) begin
            busy     <= 1'b0;
            remain_q <= '0;
        end else if (launch) begin
            busy     <= 1'b1;
            remain_q <= count;
        end else if (step) begin
            remain_q <= remain_q - 1'b1;
            // Busy drops right after the last word goes out
            if (remain_q == 16'd1) begin
                busy <= 1'b0;
            end
        end
    end

    // Address walk and fill word, payload only
    always_ff @(posedge clk_core) begin
        if (launch) begin
            addr_q  <= base.addr;
            color_q <= color;
        end else if (step) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // Launched run starts busy at the latched base
    a_launch_base: assert property (@(posedge clk_core) disable iff (rst)
        launch |=> (busy && fill_req.addr == $past(base.addr)));

    // Stalled offer keeps its word until taken
    a_fill_hold: assert property (@(posedge clk_core) disable iff (rst)
        (fill_valid && !fill_ready) |=> (fill_valid && $stable(fill_req)));

endmodule

// ==== design/cmd_processor.sv ====
`timescale 1ns/1ps

module cmd_processor (
    input  logic              clk_core,
    input  logic              rst,

    // Commands from the command FIFO
    input  logic              cmd_valid,
    input  gpu_pkg::cmd_t     cmd,
    output logic              cmd_ready,

    // Read data into the response FIFO
    output logic              rsp_valid,
    output logic [63:0]       rsp_data,
    input  logic              rsp_ready,

    // Clear engine control
    output logic              clear_start,
    output gpu_pkg::mem_req_t clear_base,
    output logic [31:0]       clear_color,
    output logic [15:0]       clear_count,
    input  logic              clear_busy,

    // Host write port to the arbiter
    output logic              host_valid,
    output gpu_pkg::mem_req_t host_req,
    input  logic              host_ready
);

    // ============================================================
    // Register set
    // ============================================================

    logic [gpu_pkg::MEM_ADDR_W-1:0] fb_draw_q;
    logic [gpu_pkg::MEM_DATA_W-1:0] clear_color_q;
    logic [gpu_pkg::MEM_ADDR_W-1:0] mem_addr_q;

    // Decode of the command at the FIFO head
    logic is_read;
    logic is_write;
    logic hit_clear;
    logic hit_mem_data;
    logic stall;

    assign is_read      = cmd_valid && cmd.rw;
    assign is_write     = cmd_valid && !cmd.rw;
    assign hit_clear    = is_write && (cmd.addr == gpu_pkg::REG_CLEAR);
    assign hit_mem_data = is_write && (cmd.addr == gpu_pkg::REG_MEM_DATA);

    // Stall rules
    // Read waits for response space
    // Data write waits while the previous host write is pending
    // Clear waits for the engine to go idle
    assign stall = (is_read && !rsp_ready)
                 || (hit_mem_data && host_valid && !host_ready)
                 || (hit_clear && clear_busy);

    // Ready doubles as the retire strobe
    assign cmd_ready = cmd_valid && !stall;

    // ============================================================
    // Read responses
    // ============================================================

    // Response pushed in the same cycle the read retires
    assign rsp_valid = is_read;

    always_comb begin
        case (cmd.addr)
            gpu_pkg::REG_FB_DRAW:     rsp_data = 64'(fb_draw_q);
            gpu_pkg::REG_CLEAR_COLOR: rsp_data = 64'(clear_color_q);
            gpu_pkg::REG_MEM_ADDR:    rsp_data = 64'(mem_addr_q);
            gpu_pkg::REG_ID:          rsp_data = gpu_pkg::GPU_ID;
            // Write-only strobes and unmapped space
            default:                  rsp_data = '0;
        endcase
    end

    // ============================================================
    // Clear launch
    // ============================================================

    // Zero-length clear is dropped here
    assign clear_start = cmd_ready && hit_clear && (cmd.data[15:0] != 16'd0);
    assign clear_count = cmd.data[15:0];
    assign clear_color = clear_color_q;

    always_comb begin
        clear_base      = '0;
        clear_base.addr = fb_draw_q;
    end

    // ============================================================
    // Register and host write updates
    // ============================================================

    always_ff @(posedge clk_core) begin
        if (rst) begin
            fb_draw_q     <= '0;
            clear_color_q <= '0;
            mem_addr_q    <= '0;
            host_valid    <= 1'b0;
        end else begin
            if (cmd_ready && is_write) begin
                case (cmd.addr)
                    gpu_pkg::REG_FB_DRAW:
                        fb_draw_q <= cmd.data[gpu_pkg::MEM_ADDR_W-1:0];
                    gpu_pkg::REG_CLEAR_COLOR:
                        clear_color_q <= cmd.data[gpu_pkg::MEM_DATA_W-1:0];
                    gpu_pkg::REG_MEM_ADDR:
                        mem_addr_q <= cmd.data[gpu_pkg::MEM_ADDR_W-1:0];
                    // Pointer steps after each data word
                    gpu_pkg::REG_MEM_DATA:
                        mem_addr_q <= mem_addr_q + 1'b1;
                    default: ;
                endcase
            end
            // New request may replace one accepted this same cycle
            if (cmd_ready && hit_mem_data) begin
                host_valid <= 1'b1;
            end else if (host_ready) begin
                host_valid <= 1'b0;
            end
        end
    end

    // One-entry host write request, payload only
    always_ff @(posedge clk_core) begin
        if (cmd_ready && hit_mem_data) begin
            host_req.addr <= mem_addr_q;
            host_req.data <= cmd.data[gpu_pkg::MEM_DATA_W-1:0];
        end
    end

    // Clear only launched into an idle engine, which then goes busy
    a_clear_handoff: assert property (@(posedge clk_core) disable iff (rst)
        clear_start |-> !clear_busy ##1 clear_busy);

endmodule

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DEPTH         = 4,
    parameter int ALMOST_MARGIN = 1,
    parameter type T            = logic [7:0]
) (
    input  logic clk_core,
    input  logic rst,
    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,
    output logic out_valid,
    output T     out_data,
    input  logic out_ready,
    output logic almost_full,
    output logic empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    // Circular storage, payload only
    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    // Wrap at DEPTH, works for any depth
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
        if (p == AW'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Flags straight from occupancy
    assign in_ready    = (count != CW'(DEPTH));
    assign out_valid   = (count != '0);
    assign empty       = (count == '0);
    assign almost_full = (count >= CW'(DEPTH - ALMOST_MARGIN));
    assign out_data    = mem[rd_ptr];

    always_ff @(posedge clk_core) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop) rd_ptr <= ptr_next(rd_ptr);
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Empty or full storage has the pointers lined up
    a_ptr_match: assert property (@(posedge clk_core) disable iff (rst)
        (count == '0 || count == CW'(DEPTH)) |-> (wr_ptr == rd_ptr));

    // Head item held until popped
    a_out_hold: assert property (@(posedge clk_core) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

    // Push into an empty FIFO is at the output one cycle later
    a_push_visible: assert property (@(posedge clk_core) disable iff (rst)
        (push && empty) |=> (out_valid && out_data == $past(in_data)));

endmodule

// ==== design/gpu_pkg.sv ====
package gpu_pkg;

    // ============================================================
    // Widths shared by the memory write path
    // ============================================================

    localparam int MEM_ADDR_W = 24;
    localparam int MEM_DATA_W = 32;

    // Register address space, 7 bits as on the host link
    typedef logic [6:0] reg_addr_t;

    // Host command word, same bit order as the command FIFO word
    // rw is bit 71, addr 70:64, data 63:0
    typedef struct packed {
        logic      rw;
        reg_addr_t addr;
        logic [63:0] data;
    } cmd_t;

    // Single framebuffer word write
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0] data;
    } mem_req_t;

    // ============================================================
    // Register map
    // ============================================================

    // Clear target and fill word
    localparam reg_addr_t REG_FB_DRAW     = 7'h40;
    localparam reg_addr_t REG_CLEAR_COLOR = 7'h41;
    // Write starts a fill, word count in data[15:0]
    localparam reg_addr_t REG_CLEAR       = 7'h42;
    // Host pointer and auto-incrementing data port
    localparam reg_addr_t REG_MEM_ADDR    = 7'h70;
    localparam reg_addr_t REG_MEM_DATA    = 7'h71;
    // Read-only identification
    localparam reg_addr_t REG_ID          = 7'h7F;

    localparam logic [63:0] GPU_ID = 64'h6770_7500_0002_0001;

endpackage
